// File: sim.f
+incdir+tests
common/board_pkg.sv
rtl/step_rate_gen.sv
rtl/perf_counters.sv
seg_display/seg_display.sv
rtl/cpu_board_top.sv
tests/tb_cpu_board_top.sv

// File: Makefile
# Verilator build, run and lint of the board wrapper testbench

VERILATOR ?= verilator
TOP ?= tb_cpu_board_top
RTL_TOP ?= cpu_board_top
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TESTS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := tests/tb_checks.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// Check counters
//////////////////////////////

int checks = 0;
int errors = 0;

// Word read back from the display
task automatic check_word(input string name, input board_pkg::word_t exp,
		input board_pkg::word_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("Fail %s expected %08h actual %08h", name, exp, act);
	end
endtask

// Segment pattern on the pins
task automatic check_seg(input string name, input board_pkg::seg_t exp,
		input board_pkg::seg_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("Fail %s expected %02h actual %02h", name, exp, act);
	end
endtask

// Anode pattern on the pins
task automatic check_an(input string name, input board_pkg::an_t exp,
		input board_pkg::an_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("Fail %s expected %02h actual %02h", name, exp, act);
	end
endtask

// Step spacing in clk cycles
task automatic check_gap(input string name, input int exp, input int act);
	checks++;
	if (act != exp) begin
		errors++;
		$display("Fail %s expected %0d actual %0d", name, exp, act);
	end
endtask

// Failures that carry no single value
task automatic note_failure(input string msg);
	checks++;
	errors++;
	$display("%s", msg);
endtask

`endif

// File: tests/tb_cpu_board_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_board_top;

	// Short periods for simulation
	localparam int STEP_BASE = 4;
	localparam int SCAN_DIV = 3;
	localparam int RAND_SEED = 86925;
	// Rate 3 spacing runs about 8000 cycles, all display reads under 1500
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk = 1'b0;
	logic rst;
	logic clr;
	logic go;
	board_pkg::rate_sel_t rate_sel;
	board_pkg::show_sel_t show_sel;
	board_pkg::word_t led_data;
	board_pkg::cpu_events_t cpu_events;
	logic cpu_step;
	board_pkg::seg_t seg;
	board_pkg::an_t an;

	// Posedge count, read at negedges
	int cycles = 0;
	// Own copy of the statistics
	board_pkg::perf_counts_t model = '0;

	`include "tb_checks.svh"

	cpu_board_top #(
		.STEP_BASE(STEP_BASE),
		.SCAN_DIV(SCAN_DIV)
	) dut_i (
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.go        (go),
		.rate_sel  (rate_sel),
		.show_sel  (show_sel),
		.led_data  (led_data),
		.cpu_events(cpu_events),
		.cpu_step  (cpu_step),
		.seg       (seg),
		.an        (an)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	//////////////////////////////
	// Reference counts
	//////////////////////////////

	// Inputs seen here are the ones sampled on the next edge
	always @(negedge clk) begin
		if (rst || clr) begin
			model <= '0;
		end else if (cpu_step) begin
			model.steps <= model.steps + 1;
			model.branches <= model.branches + board_pkg::word_t'(cpu_events.branch);
			model.jumps <= model.jumps + board_pkg::word_t'(cpu_events.jump);
			model.load_use <= model.load_use + board_pkg::word_t'(cpu_events.load_use);
			model.redirects <= model.redirects + board_pkg::word_t'(cpu_events.redirect);
		end
	end

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles, a test never finished", TIMEOUT_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Base times 1, 10, 100, 1000
	function automatic int step_period(input board_pkg::rate_sel_t r);
		case (r)
			2'd0: return STEP_BASE;
			2'd1: return STEP_BASE * 10;
			2'd2: return STEP_BASE * 100;
			default: return STEP_BASE * 1000;
		endcase
	endfunction

	function automatic board_pkg::word_t expected_count(input board_pkg::show_sel_t sel);
		case (sel)
			3'd1: return model.steps;
			3'd2: return model.branches;
			3'd3: return model.jumps;
			3'd4: return model.load_use;
			default: return model.redirects;
		endcase
	endfunction

	// Pattern back to its hex digit
	function automatic board_pkg::nibble_t seg_nibble(input board_pkg::seg_t s);
		for (int n = 0; n < 16; n++) begin
			if (board_pkg::hex_to_seg(board_pkg::nibble_t'(n)) == s) begin
				return board_pkg::nibble_t'(n);
			end
		end
		return 4'h0;
	endfunction

	// Negedge of the next step, as an edge index
	task automatic wait_step(output int at);
		@(negedge clk);
		while (!cpu_step) @(negedge clk);
		at = cycles;
	endtask

	// One digit at a time, 0 to 7
	task automatic read_display(input string name, input board_pkg::word_t exp);
		board_pkg::word_t got;
		board_pkg::an_t lit;
		int d;
		got = '0;
		for (d = 0; d < 8; d++) begin
			lit = ~(board_pkg::an_t'(1) << d);
			@(negedge clk);
			while (an !== lit) @(negedge clk);
			check_seg($sformatf("%s digit %0d", name, d),
				board_pkg::hex_to_seg(exp[d*4 +: 4]), seg);
			got[d*4 +: 4] = seg_nibble(seg);
		end
		check_word(name, exp, got);
	endtask

	// Word register plus pin register
	task automatic show_and_read(input string name, input board_pkg::show_sel_t sel,
			input board_pkg::word_t exp);
		@(posedge clk);
		show_sel <= sel;
		repeat (3) @(negedge clk);
		read_display(name, exp);
	endtask

	// Stop steps and let the last one land
	task automatic pause_steps();
		@(posedge clk);
		go <= 1'b0;
		repeat (4) @(negedge clk);
	endtask

	// Events held for one to three steps each
	task automatic run_steps(input int n);
		int held;
		int i;
		int t;
		logic [3:0] ev_bits;
		held = 0;
		@(posedge clk);
		go <= 1'b1;
		for (i = 0; i < n; i++) begin
			if (held == 0) begin
				@(posedge clk);
				ev_bits = 4'($urandom);
				cpu_events <= ev_bits;
				held = $urandom_range(3, 1);
			end
			wait_step(t);
			held--;
		end
	endtask

	task automatic counters_match(input string name);
		int s;
		for (s = 1; s <= 5; s++) begin
			show_and_read($sformatf("%s sel %0d", name, s), board_pkg::show_sel_t'(s),
				expected_count(board_pkg::show_sel_t'(s)));
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic reset_state();
		int start;
		int i;
		start = errors;
		@(negedge clk);
		if (cpu_step !== 1'b0) note_failure("reset_state: cpu_step not low right after reset");
		check_an("reset_state an", '1, an);
		check_seg("reset_state seg", '1, seg);
		// Scanning starts on the first tick
		while (an === '1) @(negedge clk);
		for (i = 0; i < 16 * SCAN_DIV; i++) begin
			if ($countones(an) != 7) begin
				note_failure($sformatf("reset_state: anodes %02h not one digit", an));
			end
			@(negedge clk);
		end
		$display("reset_state finished, %0d errors", errors - start);
	endtask

	task automatic step_spacing();
		int start;
		int i;
		int t0;
		int t1;
		int t2;
		int period;
		board_pkg::rate_sel_t r;
		start = errors;
		for (i = 0; i < 4; i++) begin
			// 1, 2, 3, then back to 0
			r = board_pkg::rate_sel_t'(i + 1);
			period = step_period(r);
			@(posedge clk);
			rate_sel <= r;
			@(negedge clk);
			t0 = cycles;
			wait_step(t1);
			// Switch is sampled on the edge after it is driven
			check_gap($sformatf("step_spacing rate %0d first", r), period + 1, t1 - t0);
			wait_step(t2);
			check_gap($sformatf("step_spacing rate %0d gap", r), period, t2 - t1);
		end
		$display("step_spacing finished, %0d errors", errors - start);
	endtask

	task automatic go_gating();
		int start;
		int i;
		int pulses;
		int t_ref;
		int t_go;
		int t_new;
		int period;
		int k;
		start = errors;
		pulses = 0;
		period = step_period(rate_sel);
		wait_step(t_ref);
		@(posedge clk);
		go <= 1'b0;
		for (i = 0; i < 5 * period; i++) begin
			@(negedge clk);
			if (cpu_step) pulses++;
		end
		if (pulses != 0) begin
			note_failure($sformatf("go_gating: %0d steps while go was low", pulses));
		end
		@(posedge clk);
		go <= 1'b1;
		@(negedge clk);
		t_go = cycles;
		wait_step(t_new);
		// First grid point whose edge samples go high
		k = (t_go + 1 - t_ref + period - 1) / period;
		check_gap("go_gating resume", k * period, t_new - t_ref);
		$display("go_gating finished, %0d errors", errors - start);
	endtask

	task automatic event_counts();
		int start;
		start = errors;
		run_steps(24);
		pause_steps();
		counters_match("event_counts");
		$display("event_counts finished, %0d errors", errors - start);
	endtask

	task automatic source_select();
		int start;
		board_pkg::word_t val;
		start = errors;
		val = $urandom;
		@(posedge clk);
		led_data <= val;
		show_and_read("source_select led", 3'd0, val);
		// Upper codes fold onto redirects
		show_and_read("source_select sel 6", 3'd6, model.redirects);
		show_and_read("source_select sel 7", 3'd7, model.redirects);
		$display("source_select finished, %0d errors", errors - start);
	endtask

	task automatic clear_counters();
		int start;
		int s;
		start = errors;
		@(posedge clk);
		clr <= 1'b1;
		@(posedge clk);
		clr <= 1'b0;
		repeat (2) @(negedge clk);
		for (s = 1; s <= 5; s++) begin
			show_and_read($sformatf("clear_counters zero sel %0d", s),
				board_pkg::show_sel_t'(s), '0);
		end
		// Counting again from zero
		run_steps(6);
		pause_steps();
		counters_match("clear_counters recount");
		$display("clear_counters finished, %0d errors", errors - start);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(RAND_SEED));
		rst = 1'b1;
		clr = 1'b0;
		go = 1'b1;
		rate_sel = 2'd0;
		show_sel = 3'd0;
		led_data = '0;
		cpu_events = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		reset_state();
		step_spacing();
		go_gating();
		event_counts();
		source_select();
		clear_counters();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/cpu_board_top.sv
`timescale 1ns/100ps
`default_nettype none

// Board wrapper around the pipelined CPU
module cpu_board_top #(
	parameter int STEP_BASE = board_pkg::STEP_BASE_DEFAULT,
	parameter int SCAN_DIV = board_pkg::SCAN_DIV_DEFAULT
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   clr,
	input  logic                   go,
	input  board_pkg::rate_sel_t   rate_sel,
	input  board_pkg::show_sel_t   show_sel,
	input  board_pkg::word_t       led_data,
	input  board_pkg::cpu_events_t cpu_events,
	output logic                   cpu_step,
	output board_pkg::seg_t        seg,
	output board_pkg::an_t         an
);

	// Statistics toward the display
	board_pkg::perf_counts_t counts;

	//////////////////////////////
	// Input side
	//////////////////////////////

	// Step enable goes to the CPU and to the counters
	step_rate_gen #(
		.STEP_BASE(STEP_BASE)
	) step_rate_gen_i (
		.clk     (clk),
		.rst     (rst),
		.go      (go),
		.rate_sel(rate_sel),
		.step    (cpu_step)
	);

	//////////////////////////////
	// Counters and display
	//////////////////////////////

	perf_counters perf_counters_i (
		.clk   (clk),
		.rst   (rst),
		.clr   (clr),
		.step  (cpu_step),
		.events(cpu_events),
		.counts(counts)
	);

	seg_display #(
		.SCAN_DIV(SCAN_DIV)
	) seg_display_i (
		.clk     (clk),
		.rst     (rst),
		.show_sel(show_sel),
		.led_data(led_data),
		.counts  (counts),
		.seg     (seg),
		.an      (an)
	);

endmodule

`default_nettype wire

// File: seg_display/seg_display.sv
`timescale 1ns/100ps
`default_nettype none

// Eight-digit scanned hex display of one selected word
module seg_display #(
	parameter int SCAN_DIV = board_pkg::SCAN_DIV_DEFAULT
) (
	input  logic                    clk,
	input  logic                    rst,
	input  board_pkg::show_sel_t    show_sel,
	input  board_pkg::word_t        led_data,
	input  board_pkg::perf_counts_t counts,
	output board_pkg::seg_t         seg,
	output board_pkg::an_t          an
);

	board_pkg::word_t shown;
	board_pkg::word_t scan_cnt;
	logic scan_tick;
	logic scan_on;
	logic [2:0] dig;
	board_pkg::nibble_t nib;

	//////////////////////////////
	// Source select
	//////////////////////////////

	always_ff @(posedge clk) begin
		case (show_sel)
			board_pkg::SHOW_LED: shown <= led_data;
			board_pkg::SHOW_STEPS: shown <= counts.steps;
			board_pkg::SHOW_BRANCH: shown <= counts.branches;
			board_pkg::SHOW_JUMP: shown <= counts.jumps;
			board_pkg::SHOW_LOAD_USE: shown <= counts.load_use;
			// Codes 5 to 7 all show redirects
			default: shown <= counts.redirects;
		endcase
	end

	//////////////////////////////
	// Scan divider
	//////////////////////////////

	assign scan_tick = (scan_cnt == board_pkg::word_t'(SCAN_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			scan_cnt <= '0;
			scan_on <= 1'b0;
			dig <= 3'd0;
		end else begin
			if (scan_tick) begin
				scan_cnt <= '0;
			end else begin
				scan_cnt <= scan_cnt + 1'b1;
			end
			// First tick starts at digit 0
			if (scan_tick) begin
				scan_on <= 1'b1;
			end
			// Later ticks step 0..7 and wrap
			if (scan_tick && scan_on) begin
				dig <= dig + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Digit drive
	//////////////////////////////

	// Digit 0 is the lowest nibble
	assign nib = shown[{dig, 2'b00} +: 4];

	always_ff @(posedge clk) begin
		if (rst || !scan_on) begin
			// Dark until scanning starts
			an <= '1;
			seg <= '1;
		end else begin
			an <= ~(board_pkg::an_t'(1) << dig);
			seg <= board_pkg::hex_to_seg(nib);
		end
	end

	// One digit lit at most
	a_an_onehot : assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(~an)
	);

endmodule

`default_nettype wire

// File: rtl/perf_counters.sv
`timescale 1ns/100ps
`default_nettype none

// Statistics on the CPU event strobes
module perf_counters (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    clr,
	input  logic                    step,
	input  board_pkg::cpu_events_t  events,
	output board_pkg::perf_counts_t counts
);

	//////////////////////////////
	// Counter registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || clr) begin
			// Clear button beats any increment
			counts <= '0;
		end else if (step) begin
			// Every step counts
			counts.steps <= counts.steps + 1'b1;
			// Event bits only count on a qualified step
			counts.branches <= counts.branches
				+ board_pkg::word_t'(events.branch);
			counts.jumps <= counts.jumps
				+ board_pkg::word_t'(events.jump);
			counts.load_use <= counts.load_use
				+ board_pkg::word_t'(events.load_use);
			counts.redirects <= counts.redirects
				+ board_pkg::word_t'(events.redirect);
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Step count only climbs
	// wraps at all ones
	a_steps_mono : assert property (
		@(posedge clk) disable iff (rst)
		!clr |=> (counts.steps >= $past(counts.steps))
			|| ($past(counts.steps) == '1)
	);

	// No step, no movement on any event counter
	a_events_hold : assert property (
		@(posedge clk) disable iff (rst)
		(!step && !clr) |=> ($stable(counts.branches)
			&& $stable(counts.jumps)
			&& $stable(counts.load_use)
			&& $stable(counts.redirects))
	);

endmodule

`default_nettype wire

// File: rtl/step_rate_gen.sv
`timescale 1ns/100ps
`default_nettype none

// CPU step enable at one of four switch-selected rates
module step_rate_gen #(
	parameter int STEP_BASE = board_pkg::STEP_BASE_DEFAULT
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 go,
	input  board_pkg::rate_sel_t rate_sel,
	output logic                 step
);

	//////////////////////////////
	// Period lookup
	//////////////////////////////

	board_pkg::word_t period;
	board_pkg::word_t cnt;
	board_pkg::rate_sel_t last_sel;

	// Base times 1, 10, 100 or 1000
	assign period = board_pkg::word_t'(STEP_BASE) * board_pkg::RATE_MULT[rate_sel];

	//////////////////////////////
	// Period counter
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			last_sel <= rate_sel;
			step <= 1'b0;
		end else if (rate_sel != last_sel) begin
			// New rate, restart the grid from zero
			cnt <= '0;
			last_sel <= rate_sel;
			step <= 1'b0;
		end else if (cnt == period - 1'b1) begin
			cnt <= '0;
			// Counter keeps its grid while go is low
			step <= go;
		end else begin
			cnt <= cnt + 1'b1;
			step <= 1'b0;
		end
	end

	// Pulses stay single-cycle unless the period is one cycle
	a_step_single : assert property (
		@(posedge clk) disable iff (rst)
		(STEP_BASE > 1 && step) |=> !step
	);

endmodule

`default_nettype wire

// File: common/board_pkg.sv
`default_nettype none

package board_pkg;

	//////////////////////////////
	// Widths with a meaning
	//////////////////////////////

	// Display word or counter value
	typedef logic [31:0] word_t;
	// Step rate switches
	typedef logic [1:0] rate_sel_t;
	// Display source switches
	typedef logic [2:0] show_sel_t;
	// Active-low segments, bit 7 is the decimal point
	typedef logic [7:0] seg_t;
	// Active-low digit anodes
	typedef logic [7:0] an_t;
	typedef logic [3:0] nibble_t;

	// Strobes from the CPU, held for the step that produced them
	typedef struct packed {
		logic branch;
		logic jump;
		logic load_use;
		logic redirect;
	} cpu_events_t;

	// Statistics counters
	typedef struct packed {
		word_t steps;
		word_t branches;
		word_t jumps;
		word_t load_use;
		word_t redirects;
	} perf_counts_t;

	//////////////////////////////
	// Board constants
	//////////////////////////////

	// 1 kHz steps and 1 kHz digit refresh at 100 MHz
	localparam int STEP_BASE_DEFAULT = 100000;
	localparam int SCAN_DIV_DEFAULT = 100000;

	// Base periods per step, indexed by rate_sel
	localparam int unsigned RATE_MULT [4] = '{1, 10, 100, 1000};

	// Display sources, codes above SHOW_REDIRECT fold onto it
	localparam show_sel_t SHOW_LED = 3'd0;
	localparam show_sel_t SHOW_STEPS = 3'd1;
	localparam show_sel_t SHOW_BRANCH = 3'd2;
	localparam show_sel_t SHOW_JUMP = 3'd3;
	localparam show_sel_t SHOW_LOAD_USE = 3'd4;
	localparam show_sel_t SHOW_REDIRECT = 3'd5;

	// Hex digit to segment pattern, gfedcba in bits 6..0, dp kept dark
	function automatic seg_t hex_to_seg(input nibble_t nib);
		seg_t s;
		case (nib)
			4'h0: s = 8'hC0;
			4'h1: s = 8'hF9;
			4'h2: s = 8'hA4;
			4'h3: s = 8'hB0;
			4'h4: s = 8'h99;
			4'h5: s = 8'h92;
			4'h6: s = 8'h82;
			4'h7: s = 8'hF8;
			4'h8: s = 8'h80;
			4'h9: s = 8'h90;
			4'hA: s = 8'h88;
			4'hB: s = 8'h83;
			4'hC: s = 8'hC6;
			4'hD: s = 8'hA1;
			4'hE: s = 8'h86;
			default: s = 8'h8E;
		endcase
		return s;
	endfunction

endpackage

`default_nettype wire
